//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := ecc_mem_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/ecc_mem_config.svh
// Fixed sizes of the ECC memory; no module takes these as parameters
// Codeword width must equal data width plus 7 check bits
// Address width must cover the full depth

`ifndef ECC_MEM_CONFIG_SVH
`define ECC_MEM_CONFIG_SVH

// User data word and stored codeword, in bits
`define ECC_DATA_W 32
`define ECC_CODE_W 39

// Bank size in words and its address width
`define MEM_DEPTH 256
`define MEM_ADDR_W 8

// Width of each saturating event counter
`define ECC_CNT_W 16

`endif

//--- rtl/bank_if.sv
// Single-port bank access bundle, no handshake beyond req
// rdata is valid one cycle after a read request and holds until the next read

interface bank_if
  import ecc_pkg::*, mem_pkg::*;
();

  logic      req;
  logic      we;
  mem_addr_t addr;
  ecc_code_t wdata;
  ecc_code_t rdata;

  // Arbiter side
  modport master (output req, output we, output addr, output wdata, input rdata);

  // Memory side
  modport slave (input req, input we, input addr, input wdata, output rdata);

endinterface

//--- rtl/ecc_mem_top.sv
// ECC-protected 256 x 32 memory with background scrubber
// Reads return one cycle after the request, writes land at their edge
// The user port is never stalled; scrubbing uses idle bank cycles only

module ecc_mem_top
  import ecc_pkg::*, mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      we_i,
  input  mem_addr_t addr_i,
  input  ecc_data_t wdata_i,
  input  ecc_code_t inj_mask_i,
  input  logic      scrub_en_i,
  output ecc_data_t rdata_o,
  output logic      rvalid_o,
  output logic      err_single_o,
  output logic      err_double_o,
  output err_cnt_t  corrected_cnt_o,
  output err_cnt_t  uncorrectable_cnt_o
);

  ecc_code_t enc_code;
  logic      usr_rd;
  logic      scrub_corrected;
  logic      scrub_uncorrectable;

  bank_if bank_bus ();

  // Read strobe for the output side
  assign usr_rd = req_i & ~we_i;

  // Input side
  ecc_secded_enc i_enc (
    .data_i     (wdata_i),
    .inj_mask_i (inj_mask_i),
    .code_o     (enc_code)
  );

  // Arbitration and scrubbing
  ecc_scrubber i_scrubber (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .scrub_en_i            (scrub_en_i),
    .usr_req_i             (req_i),
    .usr_we_i              (we_i),
    .usr_addr_i            (addr_i),
    .usr_code_i            (enc_code),
    .bank                  (bank_bus.master),
    .scrub_corrected_o     (scrub_corrected),
    .scrub_uncorrectable_o (scrub_uncorrectable)
  );

  sram_bank i_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bank   (bank_bus.slave)
  );

  // Output side
  ecc_read_port i_read_port (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .usr_rd_i              (usr_rd),
    .code_i                (bank_bus.rdata),
    .scrub_corrected_i     (scrub_corrected),
    .scrub_uncorrectable_i (scrub_uncorrectable),
    .rdata_o               (rdata_o),
    .rvalid_o              (rvalid_o),
    .err_single_o          (err_single_o),
    .err_double_o          (err_double_o),
    .corrected_cnt_o       (corrected_cnt_o),
    .uncorrectable_cnt_o   (uncorrectable_cnt_o)
  );

endmodule

//--- rtl/ecc_pkg.sv
// Types of the SECDED code: data, codeword, syndrome and error class
// Codeword layout is {check[6:0], data[31:0]}, check bits at the top

`include "ecc_mem_config.svh"

package ecc_pkg;

  typedef logic [`ECC_DATA_W-1:0] ecc_data_t;
  typedef logic [`ECC_CODE_W-1:0] ecc_code_t;
  typedef logic [`ECC_CODE_W-`ECC_DATA_W-1:0] ecc_synd_t;

  // One H-matrix column per codeword bit
  typedef ecc_synd_t [`ECC_CODE_W-1:0] ecc_hmat_t;

  // Single means the syndrome matches a column, any other nonzero one is double
  typedef enum logic [1:0] {
    ERR_NONE,
    ERR_SINGLE,
    ERR_DOUBLE
  } ecc_err_e;

  // Hsiao H matrix built at elaboration
  function automatic ecc_hmat_t ecc_hmatrix();
    ecc_hmat_t   h;
    int unsigned n;
    h = '0;
    n = 0;
    // Data columns take the first distinct weight-3 patterns
    for (int unsigned v = 0; v < 2 ** $bits(ecc_synd_t); v++) begin
      if ($countones(v) == 3 && n < `ECC_DATA_W) begin
        h[n] = ecc_synd_t'(v);
        n++;
      end
    end
    // Check bits form the identity part
    for (int unsigned k = 0; k < $bits(ecc_synd_t); k++) begin
      h[`ECC_DATA_W+k] = ecc_synd_t'(1 << k);
    end
    return h;
  endfunction

endpackage

//--- rtl/ecc_read_port.sv
// User read side: decodes bank data one cycle after a user read
// Flags apply to user reads only, scrub reads are never reported here
// Counters saturate at all ones and clear only on reset

`include "ecc_mem_config.svh"

module ecc_read_port
  import ecc_pkg::*, mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      usr_rd_i,
  input  ecc_code_t code_i,
  input  logic      scrub_corrected_i,
  input  logic      scrub_uncorrectable_i,
  output ecc_data_t rdata_o,
  output logic      rvalid_o,
  output logic      err_single_o,
  output logic      err_double_o,
  output err_cnt_t  corrected_cnt_o,
  output err_cnt_t  uncorrectable_cnt_o
);

  logic       rd_q;
  ecc_err_e   rd_err;
  logic [1:0] corr_inc;
  logic [1:0] unc_inc;

  // Add up to two events in a cycle, stick at the top
  function automatic err_cnt_t sat_add(input err_cnt_t cnt, input logic [1:0] inc);
    logic [`ECC_CNT_W:0] sum;
    sum = {1'b0, cnt} + {{(`ECC_CNT_W-1){1'b0}}, inc};
    if (sum[`ECC_CNT_W]) begin
      return '1;
    end
    return sum[`ECC_CNT_W-1:0];
  endfunction

  ecc_secded_dec i_rd_dec (
    .code_i (code_i),
    .data_o (rdata_o),
    .code_o (),
    .err_o  (rd_err)
  );

  // Marks the cycle in which bank data belongs to a user read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= usr_rd_i;
    end
  end

  assign rvalid_o     = rd_q;
  assign err_single_o = rd_q && (rd_err == ERR_SINGLE);
  assign err_double_o = rd_q && (rd_err == ERR_DOUBLE);

  // User and scrub events merged per counter
  assign corr_inc = {1'b0, err_single_o} + {1'b0, scrub_corrected_i};
  assign unc_inc  = {1'b0, err_double_o} + {1'b0, scrub_uncorrectable_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      corrected_cnt_o     <= '0;
      uncorrectable_cnt_o <= '0;
    end else begin
      corrected_cnt_o     <= sat_add(corrected_cnt_o, corr_inc);
      uncorrectable_cnt_o <= sat_add(uncorrectable_cnt_o, unc_inc);
    end
  end

  a_flags_exclusive : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(err_single_o && err_double_o));

endmodule

//--- rtl/ecc_scrubber.sv
// Bank arbiter plus background scrub FSM; the user port always wins
// Only correctable words are rewritten, double errors are reported and left
// A step in progress completes even after scrub_en_i drops

module ecc_scrubber
  import ecc_pkg::*, mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      scrub_en_i,
  input  logic      usr_req_i,
  input  logic      usr_we_i,
  input  mem_addr_t usr_addr_i,
  input  ecc_code_t usr_code_i,
  bank_if.master    bank,
  output logic      scrub_corrected_o,
  output logic      scrub_uncorrectable_o
);

  scrub_state_e state_d, state_q;
  mem_addr_t    addr_d, addr_q;

  logic      scrub_req;
  logic      scrub_we;
  ecc_code_t fixed_code;
  ecc_err_e  scrub_err;

  // Checks the word read back in SCRUB_WRITE
  ecc_secded_dec i_scrub_dec (
    .code_i (bank.rdata),
    .data_o (),
    .code_o (fixed_code),
    .err_o  (scrub_err)
  );

  // User request owns the bank, scrub fills idle cycles only
  always_comb begin
    bank.req = usr_req_i | scrub_req;
    if (usr_req_i) begin
      bank.we    = usr_we_i;
      bank.addr  = usr_addr_i;
      bank.wdata = usr_code_i;
    end else begin
      bank.we    = scrub_we;
      bank.addr  = addr_q;
      bank.wdata = fixed_code;
    end
  end

  always_comb begin
    state_d               = state_q;
    addr_d                = addr_q;
    scrub_req             = 1'b0;
    scrub_we              = 1'b0;
    scrub_corrected_o     = 1'b0;
    scrub_uncorrectable_o = 1'b0;
    unique case (state_q)
      SCRUB_IDLE: begin
        if (scrub_en_i) begin
          state_d = SCRUB_READ;
        end
      end
      SCRUB_READ: begin
        // Read goes out only when the user is quiet, else stall here
        scrub_req = 1'b1;
        if (!usr_req_i) begin
          state_d = SCRUB_WRITE;
        end
      end
      SCRUB_WRITE: begin
        if (scrub_err != ERR_SINGLE) begin
          // Clean or uncorrectable, nothing to write back
          state_d               = SCRUB_IDLE;
          addr_d                = addr_q + mem_addr_t'(1);
          scrub_uncorrectable_o = (scrub_err == ERR_DOUBLE);
        end else if (usr_req_i) begin
          // User took the bank, word may have changed so read it again
          state_d = SCRUB_READ;
        end else begin
          scrub_req         = 1'b1;
          scrub_we          = 1'b1;
          state_d           = SCRUB_IDLE;
          addr_d            = addr_q + mem_addr_t'(1);
          scrub_corrected_o = 1'b1;
        end
      end
      default: begin
        state_d = SCRUB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SCRUB_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  // Scrub writes happen only for a correctable word, in a user-free cycle
  a_scrub_write_slot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bank.req && bank.we && !usr_req_i)
      |-> (state_q == SCRUB_WRITE && scrub_err == ERR_SINGLE));

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {SCRUB_IDLE, SCRUB_READ, SCRUB_WRITE});

endmodule

//--- rtl/ecc_secded_dec.sv
// Hsiao 39/32 decoder, purely combinational
// Corrects any single-bit error, including one in the check bits
// A double error is flagged and the codeword passes through unchanged

`include "ecc_mem_config.svh"

module ecc_secded_dec
  import ecc_pkg::*;
(
  input  ecc_code_t code_i,
  output ecc_data_t data_o,
  output ecc_code_t code_o,
  output ecc_err_e  err_o
);

  localparam ecc_hmat_t H = ecc_hmatrix();

  ecc_synd_t synd;
  ecc_code_t flip;

  // Syndrome over the whole codeword, zero for a clean word
  always_comb begin
    synd = '0;
    for (int i = 0; i < `ECC_CODE_W; i++) begin
      if (code_i[i]) begin
        synd ^= H[i];
      end
    end
  end

  // Columns are odd weight and distinct, so at most one bit matches
  // Double errors give even weight and match none
  always_comb begin
    for (int i = 0; i < `ECC_CODE_W; i++) begin
      flip[i] = (synd == H[i]);
    end
  end

  assign code_o = code_i ^ flip;
  assign data_o = code_o[`ECC_DATA_W-1:0];

  // Error class from syndrome and match
  always_comb begin
    if (synd == '0) begin
      err_o = ERR_NONE;
    end else if (|flip) begin
      err_o = ERR_SINGLE;
    end else begin
      err_o = ERR_DOUBLE;
    end
  end

endmodule

//--- rtl/ecc_secded_enc.sv
// Hsiao 39/32 encoder, purely combinational
// inj_mask_i is XORed onto the codeword; keep it zero in normal operation

`include "ecc_mem_config.svh"

module ecc_secded_enc
  import ecc_pkg::*;
(
  input  ecc_data_t data_i,
  input  ecc_code_t inj_mask_i,
  output ecc_code_t code_o
);

  // Same matrix as the decoder, generated from the package
  localparam ecc_hmat_t H = ecc_hmatrix();

  ecc_synd_t check;

  // Each check bit is the parity over the data bits in its row
  always_comb begin
    check = '0;
    for (int i = 0; i < `ECC_DATA_W; i++) begin
      if (data_i[i]) begin
        check ^= H[i];
      end
    end
  end

  // Planted faults enter the stored word here
  assign code_o = {check, data_i} ^ inj_mask_i;

endmodule

//--- rtl/mem_pkg.sv
// Types of the bank side: address, event count and scrub FSM states
// Address wraps at the bank depth, so the scrub walk is modulo depth

`include "ecc_mem_config.svh"

package mem_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

  // Saturating counter value
  typedef logic [`ECC_CNT_W-1:0] err_cnt_t;

  // One scrub step is IDLE, READ, WRITE
  typedef enum logic [1:0] {
    SCRUB_IDLE,
    SCRUB_READ,
    SCRUB_WRITE
  } scrub_state_e;

endpackage

//--- rtl/sram_bank.sv
// Single-port synchronous memory, contents are not reset
// Read data appears one cycle after the request and holds until the next read

`include "ecc_mem_config.svh"

module sram_bank
  import ecc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  bank_if.slave bank
);

  ecc_code_t mem_q [`MEM_DEPTH];
  ecc_code_t rdata_q;

  // Write on req with we, registered read otherwise
  always_ff @(posedge clk_i) begin
    if (bank.req) begin
      if (bank.we) begin
        mem_q[bank.addr] <= bank.wdata;
      end else begin
        rdata_q <= mem_q[bank.addr];
      end
    end
  end

  assign bank.rdata = rdata_q;

  a_addr_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    bank.req |-> !$isunknown(bank.addr));

endmodule

//--- verification/ecc_mem_tb.sv
// Random-stimulus testbench for ecc_mem_top with inputs changed on the falling edge
// Model keeps written data, injected data bits and the number of injected bits per address
// Counters are checked only while no scrub step can be in flight

`include "ecc_mem_config.svh"

module ecc_mem_tb
  import ecc_pkg::*, mem_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int N_RD       = 64;
  localparam int N_ERR      = 32;
  localparam int N_OPS      = 300;
  localparam int SWEEP      = 3 * `MEM_DEPTH;
  // Fill, plant and re-read each cost one cycle per address
  localparam int TEST_CYCLES = 2 * RST_CYCLES + 3 * `MEM_DEPTH + SWEEP
                               + 2 * (N_RD + 2 * N_ERR + N_OPS) + 64;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      req, we, scrub_en;
  mem_addr_t addr;
  ecc_data_t wdata, rdata;
  ecc_code_t inj_mask;
  logic      rvalid, err_single, err_double;
  err_cnt_t  corr_cnt, unc_cnt;

  integer    seed;
  int        errors, checks, base;
  int        exp_corr, exp_unc;
  ecc_data_t model_data [`MEM_DEPTH];
  ecc_data_t inj_data [`MEM_DEPTH];
  int        err_bits [`MEM_DEPTH];

  ecc_mem_top i_dut (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .we_i (we), .addr_i (addr),
    .wdata_i (wdata), .inj_mask_i (inj_mask), .scrub_en_i (scrub_en),
    .rdata_o (rdata), .rvalid_o (rvalid), .err_single_o (err_single),
    .err_double_o (err_double), .corrected_cnt_o (corr_cnt),
    .uncorrectable_cnt_o (unc_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Up to two distinct codeword bits set, nbits says how many
  function automatic ecc_code_t make_mask(input int nbits);
    int unsigned b0, b1;
    ecc_code_t   m;
    b0 = rand_below(`ECC_CODE_W);
    b1 = (b0 + 1 + rand_below(`ECC_CODE_W - 1)) % `ECC_CODE_W;
    m  = '0;
    if (nbits > 0) m[b0] = 1'b1;
    if (nbits > 1) m[b1] = 1'b1;
    return m;
  endfunction

  task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic write_word(input mem_addr_t a, input int nbits);
    req      = 1'b1;
    we       = 1'b1;
    addr     = a;
    wdata    = $random(seed);
    inj_mask = make_mask(nbits);
    model_data[a] = wdata;
    inj_data[a]   = inj_mask[`ECC_DATA_W-1:0];
    err_bits[a]   = nbits;
    @(negedge clk);
    req      = 1'b0;
    we       = 1'b0;
    inj_mask = '0;
    // A write never produces read data
    expect_eq("rvalid_o after write", rvalid, 1'b0);
  endtask

  // Result is due exactly one cycle after the request edge
  task automatic read_check(input mem_addr_t a);
    logic      exp_s, exp_d;
    ecc_data_t exp_data;
    req  = 1'b1;
    we   = 1'b0;
    addr = a;
    @(negedge clk);
    req   = 1'b0;
    exp_s = (err_bits[a] == 1);
    exp_d = (err_bits[a] == 2);
    expect_eq("rvalid_o", rvalid, 1'b1);
    expect_eq("err_single_o", err_single, exp_s);
    expect_eq("err_double_o", err_double, exp_d);
    // A double error passes the stored data bits through uncorrected
    if (exp_d) begin
      exp_data = model_data[a] ^ inj_data[a];
    end else begin
      exp_data = model_data[a];
    end
    expect_eq("rdata_o", rdata, exp_data);
    exp_corr += int'(exp_s);
    exp_unc  += int'(exp_d);
  endtask

  task automatic idle();
    req = 1'b0;
    @(negedge clk);
    expect_eq("rvalid_o idle", rvalid, 1'b0);
  endtask

  task automatic check_counters();
    idle();
    expect_eq("corrected_cnt_o", corr_cnt, exp_corr);
    expect_eq("uncorrectable_cnt_o", unc_cnt, exp_unc);
  endtask

  task automatic finish_test(input string name);
    $display("%s: done, %0d errors", name, errors - base);
    base = errors;
  endtask

  // Watchdog sized from the test lengths with a factor of two margin
  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", 2 * TEST_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed     = 32'h9928927b;
    rst_n    = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    inj_mask = '0;
    scrub_en = 1'b0;
    errors   = 0;
    checks   = 0;
    base     = 0;
    exp_corr = 0;
    exp_unc  = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Every address gets a clean word before any read
    for (int a = 0; a < `MEM_DEPTH; a++) write_word(mem_addr_t'(a), 0);
    for (int i = 0; i < N_RD; i++) begin
      read_check(mem_addr_t'(rand_below(`MEM_DEPTH)));
      idle();
    end
    check_counters();
    finish_test("clean write and read");

    for (int i = 0; i < N_ERR; i++) begin
      addr = mem_addr_t'(rand_below(`MEM_DEPTH));
      write_word(addr, 1);
      read_check(addr);
    end
    check_counters();
    finish_test("single-error correction");

    for (int i = 0; i < N_ERR; i++) begin
      addr = mem_addr_t'(rand_below(`MEM_DEPTH));
      write_word(addr, 2);
      read_check(addr);
    end
    check_counters();
    finish_test("double-error detection");

    // Plant a mix and sweep once so that singles come back clean
    for (int a = 0; a < `MEM_DEPTH; a++) write_word(mem_addr_t'(a), rand_below(3));
    for (int a = 0; a < `MEM_DEPTH; a++) begin
      exp_corr += int'(err_bits[a] == 1);
      exp_unc  += int'(err_bits[a] == 2);
      if (err_bits[a] == 1) err_bits[a] = 0;
    end
    scrub_en = 1'b1;
    repeat (SWEEP) idle();
    scrub_en = 1'b0;
    expect_eq("corrected_cnt_o after sweep", corr_cnt, exp_corr);
    expect_eq("uncorrectable_cnt_o after sweep", unc_cnt, exp_unc);
    for (int a = 0; a < `MEM_DEPTH; a++) read_check(mem_addr_t'(a));
    check_counters();
    finish_test("scrub sweep");

    // Only clean rewrites here so the scrubber finds doubles alone
    scrub_en = 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      case (rand_below(4))
        0: write_word(mem_addr_t'(rand_below(`MEM_DEPTH)), 0);
        1, 3: read_check(mem_addr_t'(rand_below(`MEM_DEPTH)));
        default: idle();
      endcase
    end
    scrub_en = 1'b0;
    repeat (3) idle();
    expect_eq("corrected_cnt_o under scrub", corr_cnt, exp_corr);
    checks++;
    if (unc_cnt < err_cnt_t'(exp_unc)) begin
      errors++;
      $display("mismatch at %0t: uncorrectable_cnt_o is %0d, below %0d", $time, unc_cnt,
               exp_unc);
    end
    finish_test("user priority under scrubbing");

    @(negedge clk);
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n    = 1'b1;
    exp_corr = 0;
    exp_unc  = 0;
    expect_eq("corrected_cnt_o after reset", corr_cnt, 0);
    expect_eq("uncorrectable_cnt_o after reset", unc_cnt, 0);
    repeat (4) idle();
    read_check(mem_addr_t'(rand_below(`MEM_DEPTH)));
    check_counters();
    finish_test("counter reset");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/ecc_pkg.sv
rtl/mem_pkg.sv
rtl/bank_if.sv
rtl/ecc_secded_enc.sv
rtl/ecc_secded_dec.sv
rtl/ecc_scrubber.sv
rtl/sram_bank.sv
rtl/ecc_read_port.sv
rtl/ecc_mem_top.sv
verification/ecc_mem_tb.sv
